// File: design/common.sv
package common;

	// Fixed-width unsigned types shared by the whole memory stage.
	typedef logic u1;
	typedef logic [2:0] u3;
	typedef logic [7:0] u8;
	typedef logic [63:0] u64;

endpackage

// File: design/decode_pkg.sv
package decode_pkg;
	import common::*;

	// Access size as the log2 of the byte count.
	typedef enum logic [1:0] {
		MSIZE1 = 2'b00,
		MSIZE2 = 2'b01,
		MSIZE4 = 2'b10,
		MSIZE8 = 2'b11
	} msize_t;

	// One load or store as issued by the pipeline.
	typedef struct packed {
		u1 valid;
		u1 write;        // High for a store.
		u1 mem_unsigned; // Zero-extend on load.
		msize_t msize;
		u64 addr;
		u64 wdata;
	} mem_req_t;

	// Load state kept from the issue cycle to the response cycle.
	typedef struct packed {
		u1 valid;
		u1 misaligned;
		u3 addr;
		msize_t msize;
		u1 mem_unsigned;
	} load_info_t;

	// Load response.
	typedef struct packed {
		u1 valid;
		u1 misaligned;
		u64 data;
	} mem_resp_t;

endpackage

// File: design/writedata.sv
`timescale 1ns/1ns

module writedata
	import common::*;
	import decode_pkg::*;
(
	input u64 wdata,
	input u3 addr,
	input msize_t msize,
	output u64 wword,
	output u8 strobe
);

	// Replicate the low part of the store data over the whole word.
	always_comb begin
		wword = wdata;
		case (msize)
			MSIZE1: wword = {8{wdata[7:0]}};
			MSIZE2: wword = {4{wdata[15:0]}};
			MSIZE4: wword = {2{wdata[31:0]}};
			MSIZE8: wword = wdata;
			default: wword = wdata;
		endcase
	end

	// Enable only the bytes that the access covers.
	always_comb begin
		strobe = 8'h00;
		case (msize)
			MSIZE1: begin // SB
				case (addr)
					3'b000: strobe = 8'b0000_0001;
					3'b001: strobe = 8'b0000_0010;
					3'b010: strobe = 8'b0000_0100;
					3'b011: strobe = 8'b0000_1000;
					3'b100: strobe = 8'b0001_0000;
					3'b101: strobe = 8'b0010_0000;
					3'b110: strobe = 8'b0100_0000;
					3'b111: strobe = 8'b1000_0000;
					default: strobe = 8'h00;
				endcase
			end
			MSIZE2: begin // SH
				case (addr[2:1])
					2'b00: strobe = 8'b0000_0011;
					2'b01: strobe = 8'b0000_1100;
					2'b10: strobe = 8'b0011_0000;
					2'b11: strobe = 8'b1100_0000;
					default: strobe = 8'h00;
				endcase
			end
			MSIZE4: begin // SW
				case (addr[2])
					1'b0: strobe = 8'b0000_1111;
					1'b1: strobe = 8'b1111_0000;
					default: strobe = 8'h00;
				endcase
			end
			MSIZE8: begin // SD
				strobe = 8'b1111_1111;
			end
			default: begin
				strobe = 8'h00;
			end
		endcase
	end

endmodule

// File: design/mem_request.sv
`timescale 1ns/1ns

module mem_request
	import common::*;
	import decode_pkg::*;
#(
	parameter int MEM_WORDS_LOG = 8
) (
	input logic clk,
	input logic reset,
	input mem_req_t req,
	output u1 en,
	output u1 we,
	output logic [MEM_WORDS_LOG-1:0] index,
	output u64 wword,
	output u8 strobe,
	output load_info_t info
);

	u1 misaligned;
	u1 aligned_valid;
	load_info_t info_next;

	// An access must sit on a multiple of its own size.
	always_comb begin
		misaligned = 1'b0;
		case (req.msize)
			MSIZE1: misaligned = 1'b0;
			MSIZE2: misaligned = req.addr[0];
			MSIZE4: misaligned = |req.addr[1:0];
			MSIZE8: misaligned = |req.addr[2:0];
			default: misaligned = 1'b1;
		endcase
	end

	assign aligned_valid = req.valid & ~misaligned;

	// Memory is only touched by aligned requests.
	assign en = aligned_valid;
	assign we = aligned_valid & req.write;
	assign index = req.addr[3 +: MEM_WORDS_LOG]; // Doubleword index.

	writedata u_writedata (
		.wdata (req.wdata),
		.addr  (req.addr[2:0]),
		.msize (req.msize),
		.wword (wword),
		.strobe(strobe)
	);

	// What readdata needs next cycle to format the load.
	always_comb begin
		info_next.valid = req.valid & ~req.write;
		info_next.misaligned = misaligned;
		info_next.addr = req.addr[2:0];
		info_next.msize = req.msize;
		info_next.mem_unsigned = req.mem_unsigned;
	end

	// Registered alongside the memory read so both line up.
	always_ff @(posedge clk) begin
		if (reset) begin
			info.valid <= 1'b0;
		end else begin
			info <= info_next;
		end
	end

endmodule

// File: design/dmem.sv
`timescale 1ns/1ns

module dmem
	import common::*;
#(
	parameter int MEM_WORDS_LOG = 8
) (
	input logic clk,
	input u1 en,
	input u1 we,
	input logic [MEM_WORDS_LOG-1:0] index,
	input u64 wword,
	input u8 strobe,
	output u64 rword
);

	localparam int DEPTH = 2 ** MEM_WORDS_LOG;

	u64 mem [DEPTH];

	// Byte-strobed write and registered read.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				for (int i = 0; i < 8; i++) begin
					if (strobe[i]) begin
						mem[index][i*8 +: 8] <= wword[i*8 +: 8];
					end
				end
			end else begin
				rword <= mem[index]; // Held until the next read.
			end
		end
	end

endmodule

// File: design/readdata.sv
`timescale 1ns/1ns

module readdata
	import common::*;
	import decode_pkg::*;
(
	input u64 rword,
	input load_info_t info,
	output mem_resp_t resp
);

	u8 byte_sel;
	logic [15:0] half_sel;
	logic [31:0] word_sel;
	u1 sign_bit;
	u64 extended;

	// Byte lane picked by the full offset.
	always_comb begin
		byte_sel = 8'h00;
		case (info.addr)
			3'b000: byte_sel = rword[7:0];
			3'b001: byte_sel = rword[15:8];
			3'b010: byte_sel = rword[23:16];
			3'b011: byte_sel = rword[31:24];
			3'b100: byte_sel = rword[39:32];
			3'b101: byte_sel = rword[47:40];
			3'b110: byte_sel = rword[55:48];
			3'b111: byte_sel = rword[63:56];
			default: byte_sel = 8'h00;
		endcase
	end

	// Halfword lane. Bit 0 of the offset is zero when aligned.
	always_comb begin
		half_sel = 16'h0000;
		case (info.addr[2:1])
			2'b00: half_sel = rword[15:0];
			2'b01: half_sel = rword[31:16];
			2'b10: half_sel = rword[47:32];
			2'b11: half_sel = rword[63:48];
			default: half_sel = 16'h0000;
		endcase
	end

	always_comb begin
		if (info.addr[2]) begin
			word_sel = rword[63:32];
		end else begin
			word_sel = rword[31:0];
		end
	end

	// Sign or zero extension to the full register width.
	always_comb begin
		sign_bit = 1'b0;
		extended = rword;
		case (info.msize)
			MSIZE1: begin // LB, LBU
				sign_bit = info.mem_unsigned ? 1'b0 : byte_sel[7];
				extended = {{56{sign_bit}}, byte_sel};
			end
			MSIZE2: begin // LH, LHU
				sign_bit = info.mem_unsigned ? 1'b0 : half_sel[15];
				extended = {{48{sign_bit}}, half_sel};
			end
			MSIZE4: begin // LW, LWU
				sign_bit = info.mem_unsigned ? 1'b0 : word_sel[31];
				extended = {{32{sign_bit}}, word_sel};
			end
			MSIZE8: begin // LD
				extended = rword;
			end
			default: begin
				extended = rword;
			end
		endcase
	end

	always_comb begin
		resp.valid = info.valid;
		resp.misaligned = info.misaligned;
		resp.data = info.misaligned ? 64'h0 : extended; // No data on a faulting load.
	end

endmodule

// File: design/mem_unit.sv
`timescale 1ns/1ns

module mem_unit
	import common::*;
	import decode_pkg::*;
#(
	parameter int MEM_WORDS_LOG = 8
) (
	input logic clk,
	input logic reset,
	input mem_req_t req,
	output mem_resp_t resp
);

	u1 en;
	u1 we;
	logic [MEM_WORDS_LOG-1:0] index;
	u64 wword;
	u8 strobe;
	u64 rword;
	load_info_t info;

	mem_request #(
		.MEM_WORDS_LOG(MEM_WORDS_LOG)
	) u_mem_request (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.en    (en),
		.we    (we),
		.index (index),
		.wword (wword),
		.strobe(strobe),
		.info  (info)
	);

	dmem #(
		.MEM_WORDS_LOG(MEM_WORDS_LOG)
	) u_dmem (
		.clk   (clk),
		.en    (en),
		.we    (we),
		.index (index),
		.wword (wword),
		.strobe(strobe),
		.rword (rword)
	);

	readdata u_readdata (
		.rword(rword),
		.info (info),
		.resp (resp)
	);

endmodule

// File: verification/mem_unit_ref.svh
`ifndef MEM_UNIT_REF_SVH
`define MEM_UNIT_REF_SVH

// Byte image of the low 2 KiB of the data memory.
u8 shadow_mem [2048];

function automatic int size_bytes(input msize_t msize);
	return 1 << msize;
endfunction

// Aligned means the offset is a whole multiple of the access size.
function automatic u1 is_misaligned(input u64 addr, input msize_t msize);
	u3 low_mask;
	low_mask = u3'(size_bytes(msize) - 1);
	return (addr[2:0] & low_mask) != 3'b000;
endfunction

// Little-endian store of the low bytes of wdata that is dropped when misaligned.
task automatic shadow_store(input u64 addr, input msize_t msize, input u64 wdata);
	logic [10:0] idx;
	int i;
	if (!is_misaligned(addr, msize)) begin
		for (i = 0; i < size_bytes(msize); i++) begin
			idx = addr[10:0] + 11'(i);
			shadow_mem[idx] = 8'(wdata >> (8 * i));
		end
	end
endtask

function automatic mem_resp_t expected_load(input u64 addr, input msize_t msize, input u1 uns);
	mem_resp_t r;
	logic [10:0] idx;
	u64 value;
	int bits;
	int i;
	bits = 8 * size_bytes(msize);
	r.valid = 1'b1;
	r.misaligned = is_misaligned(addr, msize);
	r.data = 64'h0;
	if (!r.misaligned) begin
		value = 64'h0;
		for (i = size_bytes(msize) - 1; i >= 0; i--) begin // Highest byte first.
			idx = addr[10:0] + 11'(i);
			value = (value << 8) | {56'h0, shadow_mem[idx]};
		end
		if (!uns && bits < 64 && ((value >> (bits - 1)) & 64'h1) != 64'h0) begin
			value = value | (~64'h0 << bits);
		end
		r.data = value;
	end
	return r;
endfunction

`endif

// File: verification/mem_unit_tb.sv
`timescale 1ns/1ns

module mem_unit_tb
	import common::*;
	import decode_pkg::*;
;

	logic clk = 1'b0;
	logic reset;
	mem_req_t req;
	mem_resp_t resp;

	integer seed = 32'h9cf;
	int value_errors = 0;
	int resp_errors = 0;
	int checked = 0;

	// Expected responses and the negedge at which each must be seen.
	mem_resp_t exp_q[$];
	time exp_t[$];

	`include "mem_unit_ref.svh"

	mem_unit #(
		.MEM_WORDS_LOG(8)
	) uut (
		.clk  (clk),
		.reset(reset),
		.req  (req),
		.resp (resp)
	);

	always #10 clk = ~clk;

	// Drives one request and records what the model expects from it.
	task automatic issue(input u1 write, input u1 uns, input msize_t msize, input u64 addr,
			input u64 wdata);
		mem_req_t r;
		r.valid = 1'b1;
		r.write = write;
		r.mem_unsigned = uns;
		r.msize = msize;
		r.addr = addr;
		r.wdata = wdata;
		@(posedge clk);
		req <= r;
		if (write) begin
			shadow_store(addr, msize, wdata);
		end else begin
			exp_q.push_back(expected_load(addr, msize, uns));
			exp_t.push_back($time + 64'd30); // Sampled at the next edge and checked half a cycle later.
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			req.valid <= 1'b0;
		end
	endtask

	always @(negedge clk) begin
		mem_resp_t e;
		time t;
		if (resp.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected response at %0t with no load outstanding.", $time);
				resp_errors++;
			end else begin
				e = exp_q.pop_front();
				t = exp_t.pop_front();
				checked++;
				if ($time != t) begin
					$display("Response seen at %0t but expected at %0t.", $time, t);
					resp_errors++;
				end
				if (resp.misaligned !== e.misaligned) begin
					$display("FAILED resp.misaligned expected %h actual %h at %0t",
						e.misaligned, resp.misaligned, $time);
					value_errors++;
				end
				if (resp.data !== e.data) begin
					$display("FAILED resp.data expected %h actual %h at %0t",
						e.data, resp.data, $time);
					value_errors++;
				end
			end
		end else if (resp.valid !== 1'b0) begin
			$display("resp.valid is unknown at %0t.", $time);
			resp_errors++;
		end else if (exp_t.size() != 0 && exp_t[0] <= $time) begin
			$display("No response for the load expected at %0t.", exp_t[0]);
			void'(exp_q.pop_front());
			void'(exp_t.pop_front());
			resp_errors++;
		end
	end

	initial begin
		int n;
		int sz;
		int off;
		int u;
		logic [31:0] rnd;
		reset = 1'b1;
		req = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		idle(4); // With no requests resp must stay low.

		for (n = 0; n < 16; n++) begin
			issue(1'b1, 1'b0, MSIZE8, 64'(n * 8), {$random(seed), $random(seed)});
		end

		// Every size at every aligned offset of one doubleword.
		issue(1'b1, 1'b0, MSIZE8, 64'h40, 64'h708e_7c6a_d5b4_9382);
		for (sz = 0; sz < 4; sz++) begin
			for (off = 0; off < 8; off += 1 << sz) begin
				for (u = 0; u < 2; u++) begin
					issue(1'b0, u[0], msize_t'(sz[1:0]), 64'h40 + 64'(off), 64'h0);
				end
			end
		end

		// Partial stores keep the neighboring bytes.
		issue(1'b1, 1'b0, MSIZE1, 64'h43, 64'hdead_beef_cafe_00a5);
		issue(1'b1, 1'b0, MSIZE2, 64'h46, 64'h5555_aaaa_0000_1234);
		issue(1'b0, 1'b0, MSIZE8, 64'h40, 64'h0);
		issue(1'b1, 1'b0, MSIZE4, 64'h3c, 64'h0123_4567_89ab_cdef);
		issue(1'b0, 1'b1, MSIZE8, 64'h38, 64'h0);

		// Misaligned stores are dropped and misaligned loads return zero.
		issue(1'b1, 1'b0, MSIZE8, 64'h49, 64'hffff_ffff_ffff_ffff);
		issue(1'b1, 1'b0, MSIZE4, 64'h52, 64'hffff_ffff_ffff_ffff);
		issue(1'b1, 1'b0, MSIZE2, 64'h55, 64'hffff_ffff_ffff_ffff);
		issue(1'b0, 1'b0, MSIZE8, 64'h48, 64'h0);
		issue(1'b0, 1'b0, MSIZE8, 64'h50, 64'h0);
		issue(1'b0, 1'b0, MSIZE2, 64'h41, 64'h0);
		issue(1'b0, 1'b1, MSIZE4, 64'h46, 64'h0);
		issue(1'b0, 1'b0, MSIZE8, 64'h44, 64'h0);
		idle(3);

		for (n = 0; n < 400; n++) begin
			rnd = $random(seed);
			issue(rnd[12], rnd[13], msize_t'(rnd[9:8]), {57'h0, rnd[6:0]},
				{$random(seed), $random(seed)});
		end
		idle(1);

		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timed out waiting for %0d load responses.", exp_q.size());
			resp_errors++;
		end
		idle(2);

		$display("Checked %0d responses, %0d value errors, %0d response errors.",
			checked, value_errors, resp_errors);
		if (value_errors == 0 && resp_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: mem_unit.f
+incdir+verification
design/common.sv
design/decode_pkg.sv
design/writedata.sv
design/mem_request.sv
design/dmem.sv
design/readdata.sv
design/mem_unit.sv
verification/mem_unit_tb.sv

// File: run.sh
#!/bin/sh
# Builds the memory stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module mem_unit_tb -f mem_unit.f -o mem_unit_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

./obj_dir/mem_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	exit 1
fi

exit 0
